// ==== include/stbuf_macros.svh ====
`ifndef STBUF_MACROS_SVH
`define STBUF_MACROS_SVH

// Number of hardware strands sharing the store buffer
`define STBUF_STRANDS 4

// Line geometry, one line is sixteen bytes
`define STBUF_LINE_BYTES 16
`define STBUF_LINE_W 128

// Tag and set together address every line of the backing memory
`define STBUF_SET_W 2
`define STBUF_TAG_W 2

// Lines held by the L2 stand-in
`define STBUF_MEM_DEPTH 16

`endif

// ==== source/stbuf_core_pkg.sv ====
`include "stbuf_macros.svh"

package stbuf_core_pkg;

	// Requests coming from the pipeline side
	typedef enum logic [1:0]
	{
		NONE = 2'd0,
		STORE = 2'd1,
		FLUSH = 2'd2,
		BARRIER = 2'd3
	} core_op_t;

	// Registered request as seen by the store buffer
	typedef struct packed
	{
		core_op_t op;
		logic sync;
		logic [1:0] strand;
		logic [`STBUF_TAG_W-1:0] tag;
		logic [`STBUF_SET_W-1:0] set;
		logic [`STBUF_LINE_W-1:0] data;
		logic [`STBUF_LINE_BYTES-1:0] mask;
	} core_req_t;

	// Forwarded store data for a later load from the same strand
	typedef struct packed
	{
		logic [`STBUF_LINE_W-1:0] data;
		logic [`STBUF_LINE_BYTES-1:0] mask;
	} bypass_t;

endpackage

// ==== source/l2_if_pkg.sv ====
`include "stbuf_macros.svh"

package l2_if_pkg;

	// Operations understood by the L2 side
	typedef enum logic [1:0]
	{
		STORE = 2'd0,
		STORE_SYNC = 2'd1,
		FLUSH = 2'd2
	} l2_op_t;

	// Request to the L2, held stable until acknowledged
	typedef struct packed
	{
		l2_op_t op;
		logic [1:0] strand;
		logic [`STBUF_TAG_W+`STBUF_SET_W-1:0] addr;
		logic [`STBUF_LINE_W-1:0] data;
		logic [`STBUF_LINE_BYTES-1:0] mask;
	} l2_req_t;

	// Response, status only matters for synchronized stores
	typedef struct packed
	{
		logic [1:0] strand;
		logic status;
	} l2_resp_t;

endpackage

// ==== source/store_port.sv ====
`include "stbuf_macros.svh"

module store_port
(
	input  logic clk,
	input  logic rst_i,
	input  stbuf_core_pkg::core_op_t op_i,
	input  logic sync_i,
	input  logic [1:0] strand_i,
	input  logic [7:0] addr_i,
	input  logic [31:0] wdata_i,
	input  logic [3:0] be_i,
	output stbuf_core_pkg::core_req_t req_o
);

	stbuf_core_pkg::core_req_t req_nxt;
	logic [`STBUF_LINE_BYTES-1:0] word_mask;

	// Byte enables land on the word picked by address bits 3:2
	always_comb
	begin
		word_mask = '0;
		word_mask[{addr_i[3:2], 2'b00} +: 4] = be_i;
	end

	always_comb
	begin
		req_nxt.op = op_i;
		req_nxt.sync = sync_i;
		req_nxt.strand = strand_i;
		// Upper address bits hold the tag, the bits above the line offset hold the set
		req_nxt.tag = addr_i[7 -: `STBUF_TAG_W];
		req_nxt.set = addr_i[4 +: `STBUF_SET_W];
		// The word is copied to every slot so the mask alone selects bytes
		req_nxt.data = {(`STBUF_LINE_W / 32){wdata_i}};
		if (op_i == stbuf_core_pkg::FLUSH)
			req_nxt.mask = '0;
		else
			req_nxt.mask = word_mask;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			req_o.op <= stbuf_core_pkg::NONE;
		end
		else
		begin
			req_o <= req_nxt;
		end
	end

endmodule

// ==== source/store_buffer.sv ====
`include "stbuf_macros.svh"

module store_buffer
(
	input  logic clk,
	input  logic rst_i,
	input  stbuf_core_pkg::core_req_t req_i,
	input  logic req_ack_i,
	input  logic resp_valid_i,
	input  l2_if_pkg::l2_resp_t resp_i,
	output stbuf_core_pkg::bypass_t bypass_o,
	output logic rollback_o,
	output logic [`STBUF_STRANDS-1:0] resume_strands_o,
	output logic update_o,
	output logic [`STBUF_SET_W-1:0] update_set_o,
	output l2_if_pkg::l2_req_t l2_req_o,
	output logic req_valid_o
);

	// One entry per strand
	logic [`STBUF_STRANDS-1:0] entry_valid;
	logic [`STBUF_STRANDS-1:0] entry_acked;
	logic [`STBUF_STRANDS-1:0] entry_flush;
	logic [`STBUF_STRANDS-1:0] entry_sync;
	logic [`STBUF_TAG_W-1:0] entry_tag [`STBUF_STRANDS];
	logic [`STBUF_SET_W-1:0] entry_set [`STBUF_STRANDS];
	logic [`STBUF_LINE_W-1:0] entry_data [`STBUF_STRANDS];
	logic [`STBUF_LINE_BYTES-1:0] entry_mask [`STBUF_STRANDS];

	logic [`STBUF_STRANDS-1:0] sync_wait;
	logic [`STBUF_STRANDS-1:0] sync_complete;
	logic [`STBUF_STRANDS-1:0] sync_result;
	logic [`STBUF_STRANDS-1:0] wait_resume;

	logic issue_busy;
	logic [1:0] issue_entry;
	logic [1:0] pick_idx;
	logic pick_found;
	logic [1:0] cand;

	logic req_store;
	logic req_flush;
	logic req_any;
	logic [`STBUF_STRANDS-1:0] req_onehot;
	logic [`STBUF_STRANDS-1:0] resp_mask;
	logic [`STBUF_STRANDS-1:0] sync_req;
	logic resp_hit;
	logic collision;
	logic reject;
	logic sync_rb;
	logic enqueue;
	stbuf_core_pkg::bypass_t bypass_nxt;

	assign req_store = req_i.op == stbuf_core_pkg::STORE;
	assign req_flush = req_i.op == stbuf_core_pkg::FLUSH;
	assign req_any = req_i.op != stbuf_core_pkg::NONE;
	assign req_onehot = `STBUF_STRANDS'(1) << req_i.strand;
	assign resp_mask = resp_valid_i ? (`STBUF_STRANDS'(1) << resp_i.strand) : '0;

	// A response that frees the requesting strand's entry lets the request through
	assign resp_hit = resp_valid_i && entry_valid[resp_i.strand];
	assign collision = resp_hit && req_any && req_i.strand == resp_i.strand;
	assign reject = req_any && entry_valid[req_i.strand] && !collision;

	// First sync attempt goes out and rolls back, the retry only collects the status
	assign sync_req = (req_store && req_i.sync && !entry_valid[req_i.strand]) ? req_onehot : '0;
	assign sync_rb = |(sync_req & ~sync_complete);
	assign enqueue = (req_store || req_flush) && (!entry_valid[req_i.strand] || collision)
		&& (!(req_store && req_i.sync) || sync_rb);

	assign update_o = resp_hit;
	assign update_set_o = entry_set[resp_i.strand];

	// Forwarding only looks at the requesting strand's own entry
	always_comb
	begin
		bypass_nxt = '0;
		if (req_store && req_i.sync)
		begin
			bypass_nxt.mask = '1;
			for (int w = 0; w < `STBUF_LINE_W / 32; w++)
				bypass_nxt.data[32 * w] = sync_result[req_i.strand];
		end
		else if (req_any && entry_valid[req_i.strand] && entry_tag[req_i.strand] == req_i.tag
			&& entry_set[req_i.strand] == req_i.set)
		begin
			bypass_nxt.data = entry_data[req_i.strand];
			bypass_nxt.mask = entry_mask[req_i.strand];
		end
	end

	// Round robin, starting just after the entry issued last
	always_comb
	begin
		pick_found = 1'b0;
		pick_idx = issue_entry;
		cand = issue_entry;
		for (int k = 1; k <= `STBUF_STRANDS; k++)
		begin
			cand = issue_entry + 2'(k);
			if (!pick_found && entry_valid[cand] && !entry_acked[cand])
			begin
				pick_found = 1'b1;
				pick_idx = cand;
			end
		end
	end

	always_comb
	begin
		if (entry_flush[issue_entry])
			l2_req_o.op = l2_if_pkg::FLUSH;
		else if (entry_sync[issue_entry])
			l2_req_o.op = l2_if_pkg::STORE_SYNC;
		else
			l2_req_o.op = l2_if_pkg::STORE;
		l2_req_o.strand = issue_entry;
		l2_req_o.addr = {entry_tag[issue_entry], entry_set[issue_entry]};
		l2_req_o.data = entry_data[issue_entry];
		l2_req_o.mask = entry_mask[issue_entry];
	end

	assign req_valid_o = issue_busy;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			entry_valid <= '0;
			entry_acked <= '0;
			sync_wait <= '0;
			sync_complete <= '0;
			wait_resume <= '0;
			resume_strands_o <= '0;
			rollback_o <= 1'b0;
			issue_busy <= 1'b0;
			issue_entry <= '0;
		end
		else
		begin
			rollback_o <= reject || sync_rb;
			// Resume lands a cycle after the response so it follows the rollback
			resume_strands_o <= resp_mask & (wait_resume | sync_wait);
			wait_resume <= (wait_resume & ~resp_mask) | (reject ? req_onehot : '0);
			sync_wait <= (sync_wait | (sync_req & ~sync_complete)) & ~resp_mask;
			sync_complete <= (sync_complete | (sync_wait & resp_mask)) & ~sync_req;

			if (enqueue)
				entry_valid[req_i.strand] <= 1'b1;

			// Ack and the next pick never share a cycle
			if (issue_busy)
			begin
				if (req_ack_i)
				begin
					entry_acked[issue_entry] <= 1'b1;
					issue_busy <= 1'b0;
				end
			end
			else if (pick_found)
			begin
				issue_entry <= pick_idx;
				issue_busy <= 1'b1;
			end

			if (resp_hit)
			begin
				if (!collision)
					entry_valid[resp_i.strand] <= 1'b0;
				entry_acked[resp_i.strand] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (enqueue)
		begin
			entry_tag[req_i.strand] <= req_i.tag;
			entry_set[req_i.strand] <= req_i.set;
			entry_data[req_i.strand] <= req_i.data;
			entry_mask[req_i.strand] <= req_i.mask;
			entry_flush[req_i.strand] <= req_flush;
			entry_sync[req_i.strand] <= req_store && req_i.sync;
		end
		if (|(resp_mask & sync_wait))
			sync_result[resp_i.strand] <= resp_i.status;
		bypass_o <= bypass_nxt;
	end

endmodule

// ==== source/l2_store_target.sv ====
`include "stbuf_macros.svh"

module l2_store_target
(
	input  logic clk,
	input  logic rst_i,
	input  l2_if_pkg::l2_req_t req_i,
	input  logic req_valid_i,
	input  logic [`STBUF_TAG_W+`STBUF_SET_W-1:0] rd_addr_i,
	output logic req_ack_o,
	output logic resp_valid_o,
	output l2_if_pkg::l2_resp_t resp_o,
	output logic [`STBUF_LINE_W-1:0] rd_data_o
);

	logic [`STBUF_LINE_W-1:0] mem [`STBUF_MEM_DEPTH];

	// Per line reservation, owner is the strand of the last sync store
	logic [`STBUF_MEM_DEPTH-1:0] resv_valid;
	logic [`STBUF_MEM_DEPTH-1:0] resv_broken;
	logic [1:0] resv_owner [`STBUF_MEM_DEPTH];

	l2_if_pkg::l2_req_t req_q;
	logic stage_q;
	logic accept;
	logic is_sync;
	logic is_store;
	logic sync_ok;

	// Only one request in flight, a new one is taken once the last response is near
	assign accept = req_valid_i && !req_ack_o && !stage_q;
	assign is_sync = req_q.op == l2_if_pkg::STORE_SYNC;
	assign is_store = req_q.op == l2_if_pkg::STORE;

	// Fails only when another strand's plain store broke this strand's reservation
	assign sync_ok = !(resv_valid[req_q.addr] && resv_owner[req_q.addr] == req_q.strand
		&& resv_broken[req_q.addr]);

	assign rd_data_o = mem[rd_addr_i];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			req_ack_o <= 1'b0;
			stage_q <= 1'b0;
			resp_valid_o <= 1'b0;
			resv_valid <= '0;
			resv_broken <= '0;
			for (int i = 0; i < `STBUF_MEM_DEPTH; i++)
				mem[i] <= '0;
		end
		else
		begin
			req_ack_o <= accept;
			stage_q <= req_ack_o;
			resp_valid_o <= stage_q;
			if (stage_q)
			begin
				if (is_store || (is_sync && sync_ok))
				begin
					for (int b = 0; b < `STBUF_LINE_BYTES; b++)
						if (req_q.mask[b])
							mem[req_q.addr][8 * b +: 8] <= req_q.data[8 * b +: 8];
				end
				if (is_sync)
				begin
					resv_valid[req_q.addr] <= 1'b1;
					resv_broken[req_q.addr] <= 1'b0;
				end
				else if (is_store && resv_valid[req_q.addr]
					&& resv_owner[req_q.addr] != req_q.strand)
				begin
					resv_broken[req_q.addr] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			req_q <= req_i;
		if (stage_q)
		begin
			resp_o.strand <= req_q.strand;
			resp_o.status <= !is_sync || sync_ok;
			if (is_sync)
				resv_owner[req_q.addr] <= req_q.strand;
		end
	end

endmodule

// ==== source/stbuf_subsystem.sv ====
`include "stbuf_macros.svh"

module stbuf_subsystem
(
	input  logic clk,
	input  logic rst_i,
	input  stbuf_core_pkg::core_op_t op_i,
	input  logic sync_i,
	input  logic [1:0] strand_i,
	input  logic [7:0] addr_i,
	input  logic [31:0] wdata_i,
	input  logic [3:0] be_i,
	output stbuf_core_pkg::bypass_t bypass_o,
	output logic rollback_o,
	output logic [`STBUF_STRANDS-1:0] resume_strands_o,
	output logic update_o,
	output logic [`STBUF_SET_W-1:0] update_set_o,
	input  logic [`STBUF_TAG_W+`STBUF_SET_W-1:0] rd_addr_i,
	output logic [`STBUF_LINE_W-1:0] rd_data_o
);

	stbuf_core_pkg::core_req_t core_req;
	l2_if_pkg::l2_req_t l2_req;
	l2_if_pkg::l2_resp_t l2_resp;
	logic req_valid;
	logic req_ack;
	logic resp_valid;

	store_port store_port_inst
	(
		.clk(clk),
		.rst_i(rst_i),
		.op_i(op_i),
		.sync_i(sync_i),
		.strand_i(strand_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.be_i(be_i),
		.req_o(core_req)
	);

	store_buffer store_buffer_inst
	(
		.clk(clk),
		.rst_i(rst_i),
		.req_i(core_req),
		.req_ack_i(req_ack),
		.resp_valid_i(resp_valid),
		.resp_i(l2_resp),
		.bypass_o(bypass_o),
		.rollback_o(rollback_o),
		.resume_strands_o(resume_strands_o),
		.update_o(update_o),
		.update_set_o(update_set_o),
		.l2_req_o(l2_req),
		.req_valid_o(req_valid)
	);

	l2_store_target l2_store_target_inst
	(
		.clk(clk),
		.rst_i(rst_i),
		.req_i(l2_req),
		.req_valid_i(req_valid),
		.rd_addr_i(rd_addr_i),
		.req_ack_o(req_ack),
		.resp_valid_o(resp_valid),
		.resp_o(l2_resp),
		.rd_data_o(rd_data_o)
	);

endmodule

// ==== dv/stbuf_subsystem_tb.sv ====
`include "stbuf_macros.svh"

module stbuf_subsystem_tb;

	localparam stbuf_core_pkg::core_op_t op_none = stbuf_core_pkg::NONE;
	localparam stbuf_core_pkg::core_op_t op_store = stbuf_core_pkg::STORE;
	localparam stbuf_core_pkg::core_op_t op_flush = stbuf_core_pkg::FLUSH;
	localparam stbuf_core_pkg::core_op_t op_barrier = stbuf_core_pkg::BARRIER;
	localparam int timeout_cycles = 50;

	// The last field selects the waits with bit 0 for update_o and bit 1 for the resume pulse
	typedef struct packed
	{
		stbuf_core_pkg::core_op_t op;
		logic sync;
		logic [1:0] strand;
		logic [7:0] addr;
		logic [31:0] data;
		logic [3:0] be;
		logic enq;
		logic exp_rb;
		logic [`STBUF_LINE_BYTES-1:0] exp_mask;
		logic [31:0] exp_word;
		logic [1:0] wt;
	} row_t;

	logic clk;
	logic rst_i;
	stbuf_core_pkg::core_op_t op_i;
	logic sync_i;
	logic [1:0] strand_i;
	logic [7:0] addr_i;
	logic [31:0] wdata_i;
	logic [3:0] be_i;
	stbuf_core_pkg::bypass_t bypass_o;
	logic rollback_o;
	logic [`STBUF_STRANDS-1:0] resume_strands_o;
	logic update_o;
	logic [`STBUF_SET_W-1:0] update_set_o;
	logic [3:0] rd_addr_i;
	logic [`STBUF_LINE_W-1:0] rd_data_o;

	// Reference memory and reservation state of the L2 side
	logic [`STBUF_LINE_W-1:0] ref_mem [`STBUF_MEM_DEPTH];
	logic [`STBUF_MEM_DEPTH-1:0] resv_valid;
	logic [`STBUF_MEM_DEPTH-1:0] resv_broken;
	logic [1:0] resv_owner [`STBUF_MEM_DEPTH];

	row_t rows [$];
	int err_cnt = 0;
	int tmo_cnt = 0;
	int cycle_cnt = 0;
	int upd_cnt = 0;
	int enq_cnt = 0;

	stbuf_subsystem stbuf_subsystem_inst
	(
		.clk(clk),
		.rst_i(rst_i),
		.op_i(op_i),
		.sync_i(sync_i),
		.strand_i(strand_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.be_i(be_i),
		.bypass_o(bypass_o),
		.rollback_o(rollback_o),
		.resume_strands_o(resume_strands_o),
		.update_o(update_o),
		.update_set_o(update_set_o),
		.rd_addr_i(rd_addr_i),
		.rd_data_o(rd_data_o)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (update_o)
			upd_cnt <= upd_cnt + 1;
	end

	function automatic logic [15:0] line_mask(input logic [7:0] addr, input logic [3:0] be);
		logic [15:0] m;
		m = '0;
		m[addr[3:2] * 4 +: 4] = be;
		return m;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERR %s got %0h expected %0h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic add_row(input stbuf_core_pkg::core_op_t op, input logic sync,
		input logic [1:0] strand, input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] be, input logic enq, input logic exp_rb,
		input logic [15:0] exp_mask, input logic [31:0] exp_word, input logic [1:0] wt);
		row_t r;
		r = {op, sync, strand, addr, data, be, enq, exp_rb, exp_mask, exp_word, wt};
		rows.push_back(r);
	endtask

	// Columns are op, sync, strand, address, data, byte enables, enqueued,
	// expected rollback, expected bypass mask and word, waits
	task automatic build_table();
		// Masked store on an idle subsystem
		add_row(op_store, '0, 2'd0, 8'h47, 32'hdeadbeef, 4'h6, '1, '0, 16'h0000, '0, 2'd1);
		// A barrier from the busy strand reads the pending data and is refused
		add_row(op_store, '0, 2'd0, 8'h9c, 32'h12345678, 4'ha, '1, '0, 16'h0000, '0, 2'd0);
		add_row(op_barrier, '0, 2'd2, 8'h9c, '0, 4'h0, '0, '0, 16'h0000, '0, 2'd0);
		add_row(op_barrier, '0, 2'd0, 8'h9c, '0, 4'h0, '0, '1, 16'ha000, 32'h12345678, 2'd3);
		// A second store from a busy strand is refused and then retried
		add_row(op_store, '0, 2'd1, 8'h20, 32'ha5a50101, 4'hf, '1, '0, 16'h0000, '0, 2'd0);
		add_row(op_store, '0, 2'd1, 8'h24, 32'h5a5a0202, 4'h6, '0, '1, 16'h000f, 32'ha5a50101, 2'd3);
		add_row(op_store, '0, 2'd1, 8'h24, 32'h5a5a0202, 4'h6, '1, '0, 16'h0000, '0, 2'd1);
		// A sync store succeeds and a plain store from strand 2 then breaks the reservation
		add_row(op_store, '1, 2'd1, 8'h54, 32'hcafe0001, 4'hf, '1, '1, 16'hffff, '0, 2'd3);
		add_row(op_store, '1, 2'd1, 8'h54, 32'hcafe0001, 4'hf, '0, '0, 16'hffff, 32'h1, 2'd0);
		add_row(op_store, '0, 2'd2, 8'h58, 32'h11112222, 4'h3, '1, '0, 16'h0000, '0, 2'd1);
		add_row(op_store, '1, 2'd1, 8'h54, 32'hbeef0002, 4'hf, '1, '1, 16'hffff, '0, 2'd3);
		add_row(op_store, '1, 2'd1, 8'h54, 32'hbeef0002, 4'hf, '0, '0, 16'hffff, 32'h0, 2'd0);
		add_row(op_store, '1, 2'd1, 8'h5c, 32'h0d0d0003, 4'hc, '1, '1, 16'hffff, '0, 2'd3);
		add_row(op_store, '1, 2'd1, 8'h5c, 32'h0d0d0003, 4'hc, '0, '0, 16'hffff, 32'h1, 2'd0);
		// Flush leaves the line alone even with data and byte enables present
		add_row(op_flush, '0, 2'd3, 8'h54, 32'hffffffff, 4'hf, '1, '0, 16'h0000, '0, 2'd1);
	endtask

	// Plain stores break a foreign reservation and sync stores write only on success
	task automatic model_store(input row_t r);
		logic [3:0] line;
		logic [15:0] m;
		logic ok;
		line = r.addr[7:4];
		m = line_mask(r.addr, r.be);
		ok = 1'b1;
		if (r.op != op_store)
			return;
		if (r.sync)
		begin
			ok = !(resv_valid[line] && resv_owner[line] == r.strand && resv_broken[line]);
			resv_valid[line] = 1'b1;
			resv_broken[line] = 1'b0;
			resv_owner[line] = r.strand;
		end
		else if (resv_valid[line] && resv_owner[line] != r.strand)
			resv_broken[line] = 1'b1;
		if (ok)
		begin
			for (int b = 0; b < `STBUF_LINE_BYTES; b++)
				if (m[b])
					ref_mem[line][8 * b +: 8] = r.data[8 * (b % 4) +: 8];
		end
	endtask

	// The request lives for one cycle and rollback and bypass show up two edges after the drive
	task automatic send_request(input row_t r, output logic rb,
		output stbuf_core_pkg::bypass_t byp, output int start);
		start = cycle_cnt;
		op_i = r.op;
		sync_i = r.sync;
		strand_i = r.strand;
		addr_i = r.addr;
		wdata_i = r.data;
		be_i = r.be;
		@(posedge clk);
		#1;
		op_i = op_none;
		sync_i = 1'b0;
		@(posedge clk);
		#1;
		rb = rollback_o;
		byp = bypass_o;
	endtask

	task automatic wait_update(output int seen_at);
		int n;
		n = 0;
		seen_at = -1;
		while (!update_o && n < timeout_cycles)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (update_o)
			seen_at = cycle_cnt;
		else
		begin
			$display("Timed out waiting for update_o after %0d cycles", timeout_cycles);
			tmo_cnt++;
		end
	endtask

	task automatic wait_resume(input logic [1:0] strand);
		int n;
		n = 0;
		while (!resume_strands_o[strand] && n < timeout_cycles)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!resume_strands_o[strand])
		begin
			$display("Timed out waiting for the resume of strand %0d", strand);
			tmo_cnt++;
		end
	endtask

	task automatic check_line(input logic [3:0] line);
		rd_addr_i = line;
		@(posedge clk);
		#1;
		check_value($sformatf("rd_data_o[%0d]", line), rd_data_o, ref_mem[line]);
	endtask

	task automatic run_row(input row_t r);
		logic rb;
		stbuf_core_pkg::bypass_t byp;
		int start;
		int seen_at;
		send_request(r, rb, byp, start);
		if (r.enq)
		begin
			model_store(r);
			enq_cnt++;
		end
		check_value("rollback_o", rb, r.exp_rb);
		check_value("bypass_o.mask", byp.mask, r.exp_mask);
		// First sync attempt returns whatever status the strand held before
		if (!(r.sync && r.exp_rb))
			check_value("bypass_o.data", byp.data, {4{r.exp_word}});
		if (r.wt[0])
		begin
			wait_update(seen_at);
			if (seen_at >= 0)
			begin
				check_value("update_set_o", update_set_o, r.addr[5:4]);
				if (r.wt == 2'd1)
					check_value("update_o latency", seen_at - start, 6);
			end
		end
		if (r.wt[1])
			wait_resume(r.strand);
		if (r.wt[0])
			check_line(r.addr[7:4]);
	endtask

	task automatic random_traffic(input int count);
		row_t r;
		logic rb;
		stbuf_core_pkg::bypass_t byp;
		int start;
		int tries;
		for (int i = 0; i < count; i++)
		begin
			r = '0;
			r.op = op_store;
			r.strand = 2'($urandom);
			// Every strand writes only lines whose tag is its own number
			r.addr = {r.strand, 2'($urandom), 2'($urandom), 2'b00};
			r.data = $urandom;
			r.be = 4'($urandom % 15 + 1);
			tries = 0;
			rb = 1'b1;
			while (rb && tries < 8)
			begin
				send_request(r, rb, byp, start);
				tries++;
				if (rb)
					wait_resume(r.strand);
			end
			if (rb)
			begin
				$display("Store from strand %0d still refused after %0d tries", r.strand, tries);
				tmo_cnt++;
			end
			else
			begin
				model_store(r);
				enq_cnt++;
			end
		end
	endtask

	task automatic drain_buffer();
		int n;
		n = 0;
		while (upd_cnt != enq_cnt && n < timeout_cycles)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (upd_cnt != enq_cnt)
		begin
			$display("Timed out draining, %0d of %0d entries finished", upd_cnt, enq_cnt);
			tmo_cnt++;
		end
	endtask

	initial
	begin
		void'($urandom(32'h758d));
		rst_i = 1'b1;
		op_i = op_none;
		sync_i = 1'b0;
		strand_i = '0;
		addr_i = '0;
		wdata_i = '0;
		be_i = '0;
		rd_addr_i = '0;
		resv_valid = '0;
		resv_broken = '0;
		for (int i = 0; i < `STBUF_MEM_DEPTH; i++)
		begin
			ref_mem[i] = '0;
			resv_owner[i] = '0;
		end
		build_table();
		repeat (16) @(posedge clk);
		#1;
		rst_i = 1'b0;
		@(posedge clk);
		#1;
		check_value("rollback_o", rollback_o, 1'b0);
		check_value("update_o", update_o, 1'b0);
		check_value("resume_strands_o", resume_strands_o, '0);
		for (int i = 0; i < `STBUF_MEM_DEPTH; i++)
			check_line(4'(i));
		foreach (rows[i])
			run_row(rows[i]);
		random_traffic(32);
		drain_buffer();
		for (int i = 0; i < `STBUF_MEM_DEPTH; i++)
			check_line(4'(i));
		$display("Value errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
source/stbuf_core_pkg.sv
source/l2_if_pkg.sv
source/store_port.sv
source/store_buffer.sv
source/l2_store_target.sv
source/stbuf_subsystem.sv
dv/stbuf_subsystem_tb.sv
